/* list.f */
hdl/x25519_field_pkg.sv
hdl/x25519_seq_pkg.sv
hdl/x25519_column_mult.sv
hdl/x25519_streaming_squeeze.sv
hdl/x25519_add.sv
hdl/x25519_field_mult.sv
tests/x25519_field_mult_tb.sv

/* Bender.yml */
package:
  name: x25519_field_mult

dependencies: {}

sources:
  - hdl/x25519_field_pkg.sv
  - hdl/x25519_seq_pkg.sv
  - hdl/x25519_column_mult.sv
  - hdl/x25519_streaming_squeeze.sv
  - hdl/x25519_add.sv
  - hdl/x25519_field_mult.sv
  - target: test
    files:
      - tests/x25519_field_mult_tb.sv

/* tests/x25519_field_mult_tb.sv */
`timescale 1ns/1ns

module x25519_field_mult_tb;
	import x25519_field_pkg::*;

	localparam int CLK_PERIOD  = 8;
	localparam int NUM_RANDOM  = 32;
	localparam int NUM_CHAINED = 4;
	// Corners, random pairs, the ignored-start case and the chained run
	localparam int NUM_TESTS   = 5 + NUM_RANDOM + 1 + NUM_CHAINED;
	localparam int MAX_OPS     = 64;
	localparam logic [31:0] SEED = 32'h5209;
	// p = 2^255 - 19
	localparam field_t PRIME = {1'b0, {255{1'b1}}} - 256'd18;

	logic   clk = 1'b0;
	logic   rst_n;
	logic   start;
	field_t a;
	field_t b;
	logic   busy;
	logic   done;
	wide_t  result;

	logic [31:0] rng_state;

	// Operations in issue order, consumed by the compare process
	wide_t  exp_mem  [0:MAX_OPS-1];
	field_t a_mem    [0:MAX_OPS-1];
	field_t b_mem    [0:MAX_OPS-1];
	string  name_mem [0:MAX_OPS-1];
	int     issued;
	int     checked;
	int     checks;
	int     errors;
	logic   done_prev;

	always #(CLK_PERIOD/2) clk = ~clk;

	x25519_field_mult UUT (
		.clk    (clk),
		.rst_n  (rst_n),
		.start  (start),
		.a      (a),
		.b      (b),
		.busy   (busy),
		.done   (done),
		.result (result)
	);

	////////////////////////////////////////////////////////////////////////////
	// Reference model

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// 256 random bits from eight xorshift steps
	task automatic rand_field(output field_t v);
		for (int k = 0; k < 8; k++) begin
			rng_state = xorshift32(rng_state);
			v[k*32 +: 32] = rng_state;
		end
	endtask

	// Folded column sums, carried into t, then top bits folded back times 19
	function automatic wide_t fold_reference(input field_t x, input field_t y);
		logic [319:0] t;
		logic [319:0] colw;
		logic [63:0]  col;
		logic [63:0]  prod;
		int           i;
		int           j;
		t = '0;
		for (i = 0; i < 32; i++) begin
			col = '0;
			for (j = 0; j < 32; j++) begin
				if (j <= i) begin
					prod = 64'(x[j*8 +: 8]) * 64'(y[(i-j)*8 +: 8]);
					col  = col + prod;
				end else begin
					// Wrapped past 2^256, weight 38
					prod = 64'(x[j*8 +: 8]) * 64'(y[(i+32-j)*8 +: 8]);
					col  = col + 64'd38 * prod;
				end
			end
			colw = 320'(col);
			t    = t + (colw << (8*i));
		end
		return wide_t'(t[254:0]) + wide_t'(19) * wide_t'(t >> 255);
	endfunction

	// Plain modular check against the full 512-bit product
	function automatic logic congruent(input field_t x, input field_t y, input wide_t r);
		logic [511:0] prod;
		logic [511:0] modulus;
		logic [511:0] rr;
		modulus = 512'(PRIME);
		prod    = 512'(x) * 512'(y);
		rr      = 512'(r);
		return (prod % modulus) == (rr % modulus);
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Stimulus helpers, all called 1 ns after a rising edge

	task automatic start_op(input field_t op_a, input field_t op_b, input string name);
		if (busy) begin
			errors++;
			$display("start for %s issued while busy was still high", name);
		end
		a     = op_a;
		b     = op_b;
		start = 1'b1;
		exp_mem[issued]  = fold_reference(op_a, op_b);
		a_mem[issued]    = op_a;
		b_mem[issued]    = op_b;
		name_mem[issued] = name;
		issued++;
		@(posedge clk);
		#1;
		start = 1'b0;
	endtask

	// Returns in the cycle where done is high
	task automatic wait_done();
		@(posedge clk);
		#1;
		while (!done) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic run_op(input field_t op_a, input field_t op_b, input string name);
		start_op(op_a, op_b, name);
		wait_done();
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Compare, sampled mid-cycle

	always @(negedge clk) begin
		if (rst_n && done) begin
			if (done_prev) begin
				errors++;
				$display("done stayed high for more than one cycle");
			end
			if (busy) begin
				errors++;
				$display("busy still high in the cycle of done");
			end
			// Covers the ignored start as well
			if (checked >= issued) begin
				errors++;
				$display("done arrived with no operation pending");
			end else begin
				checks++;
				if (result !== exp_mem[checked]) begin
					errors++;
					$display("mismatch %s: expected %h, actual %h",
						name_mem[checked], exp_mem[checked], result);
				end
				if (result[WIDE_W-1:FIELD_W] != '0) begin
					errors++;
					$display("result of %s is not below 2^256", name_mem[checked]);
				end
				if (!congruent(a_mem[checked], b_mem[checked], result)) begin
					errors++;
					$display("result of %s is not congruent to a*b mod p", name_mem[checked]);
				end
				checked++;
			end
		end
		done_prev = done;
	end

	////////////////////////////////////////////////////////////////////////////
	// Test sequence

	initial begin
		field_t x;
		field_t y;
		int     i;
		rst_n     = 1'b0;
		start     = 1'b0;
		a         = '0;
		b         = '0;
		rng_state = SEED;
		issued    = 0;
		checked   = 0;
		checks    = 0;
		errors    = 0;
		done_prev = 1'b0;
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// Idle outputs before any start
		@(posedge clk);
		#1;
		checks++;
		if (busy || done) begin
			errors++;
			$display("busy or done high after reset with no start");
		end
		if (result !== '0) begin
			errors++;
			$display("mismatch reset_state: expected %h, actual %h", wide_t'(0), result);
		end

		// Corner operands
		run_op('0, '0, "zero_times_zero");
		run_op(field_t'(1), field_t'(1), "one_times_one");
		run_op(PRIME - 1, PRIME - 1, "p_minus_1_squared");
		run_op('1, '1, "all_ones_squared");
		rand_field(x);
		run_op(PRIME, x, "p_times_x");

		// Random pairs
		for (i = 0; i < NUM_RANDOM; i++) begin
			rand_field(x);
			rand_field(y);
			run_op(x, y, $sformatf("random_%0d", i));
		end

		// Second start during an operation must be dropped
		rand_field(x);
		rand_field(y);
		start_op(x, y, "start_while_busy");
		repeat (10) begin
			@(posedge clk);
			#1;
		end
		if (!busy) begin
			errors++;
			$display("busy low ten cycles into an operation");
		end
		// Fresh operands, a restart on them would change the result
		rand_field(x);
		rand_field(y);
		a     = x;
		b     = y;
		start = 1'b1;
		@(posedge clk);
		#1;
		start = 1'b0;
		wait_done();
		// Long enough for a stray second done to show up
		repeat (45) begin
			@(posedge clk);
			#1;
		end

		// Each start in the cycle right after the previous done
		for (i = 0; i < NUM_CHAINED; i++) begin
			rand_field(x);
			rand_field(y);
			run_op(x, y, $sformatf("chained_%0d", i));
		end
		repeat (4) begin
			@(posedge clk);
			#1;
		end
		if (checked != issued) begin
			errors++;
			$display("only %0d of %0d operations completed", checked, issued);
		end

		$display("checks %0d, error count %0d", checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	// Watchdog, about 40 cycles per operation plus slack
	initial begin
		#((NUM_TESTS + 4) * 40 * CLK_PERIOD);
		$display("timeout: done never arrived, %0d of %0d operations checked",
			checked, issued);
		$display("Errors found");
		$finish;
	end

endmodule

/* hdl/x25519_field_mult.sv */
`timescale 1ns/1ns

module x25519_field_mult (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      start,
	input  x25519_field_pkg::field_t  a,
	input  x25519_field_pkg::field_t  b,
	output logic                      busy,
	output logic                      done,
	output x25519_field_pkg::wide_t   result
);
	import x25519_field_pkg::*;

	// Multiplier to squeeze
	logic     clear;
	logic     col_valid;
	column_t  col;

	// Squeeze to adder
	logic     add_en;
	wide_t    add_a;
	wide_t    add_b;

	////////////////////////////////////////////////////////////////////////////
	// Datapath

	// Streams 32 folded columns, holds busy until done
	x25519_column_mult u_mult (
		.clk       (clk),
		.rst_n     (rst_n),
		.start     (start),
		.a         (a),
		.b         (b),
		.busy      (busy),
		.clear     (clear),
		.col_valid (col_valid),
		.col       (col)
	);

	// Carries into limbs, splits off the times 19 term
	x25519_streaming_squeeze u_squeeze (
		.clk       (clk),
		.rst_n     (rst_n),
		.clear     (clear),
		.col_valid (col_valid),
		.col       (col),
		.add_en    (add_en),
		.add_a     (add_a),
		.add_b     (add_b)
	);

	// Adds the fold back in, result held until the next done
	x25519_add u_add (
		.clk       (clk),
		.rst_n     (rst_n),
		.en        (add_en),
		.a         (add_a),
		.b         (add_b),
		.out_valid (done),
		.out       (result)
	);

endmodule

/* hdl/x25519_add.sv */
`timescale 1ns/1ns

module x25519_add (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     en,
	input  x25519_field_pkg::wide_t  a,
	input  x25519_field_pkg::wide_t  b,
	output logic                     out_valid,
	output x25519_field_pkg::wide_t  out
);
	import x25519_field_pkg::*;
	import x25519_seq_pkg::*;

	////////////////////////////////////////////////////////////////////////////
	// Slice pipeline

	// acc carries finished sum slices below, untouched a bits above
	for (genvar s = 0; s < ADD_STAGES; s++) begin : g_stage
		wide_t                 acc_in;
		wide_t                 opb_in;
		logic                  vld_in;
		logic                  cin;
		logic [ADD_SLICE_W:0]  slice_sum;
		wide_t                 acc_q;
		logic                  vld_q;

		if (s == 0) begin : g_first
			assign acc_in = a;
			assign opb_in = b;
			assign vld_in = en;
			assign cin    = 1'b0;
		end else begin : g_next
			assign acc_in = g_stage[s-1].acc_q;
			assign opb_in = g_stage[s-1].g_fwd.opb_q;
			assign vld_in = g_stage[s-1].vld_q;
			assign cin    = g_stage[s-1].g_fwd.carry_q;
		end

		// This stage's slice plus the carry from the one below
		assign slice_sum = {1'b0, acc_in[s*ADD_SLICE_W +: ADD_SLICE_W]}
			+ {1'b0, opb_in[s*ADD_SLICE_W +: ADD_SLICE_W]}
			+ {{ADD_SLICE_W{1'b0}}, cin};

		// Held when idle, so the last stage keeps the result
		always_ff @(posedge clk or negedge rst_n) begin
			if (!rst_n) begin
				vld_q <= 1'b0;
				acc_q <= '0;
			end else begin
				vld_q <= vld_in;
				if (vld_in) begin
					acc_q <= acc_in;
					acc_q[s*ADD_SLICE_W +: ADD_SLICE_W] <= slice_sum[ADD_SLICE_W-1:0];
				end
			end
		end

		// b and carry only needed by a following stage
		if (s < ADD_STAGES - 1) begin : g_fwd
			wide_t  opb_q;
			logic   carry_q;

			always_ff @(posedge clk) begin
				if (vld_in) begin
					opb_q   <= opb_in;
					carry_q <= slice_sum[ADD_SLICE_W];
				end
			end
		end
	end

	// Top slice carry out is dropped, sums stay below 2^256
	assign out       = g_stage[ADD_STAGES-1].acc_q;
	assign out_valid = g_stage[ADD_STAGES-1].vld_q;

	// Fixed latency, no stalls
	a_latency: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid == $past(en, ADD_STAGES));

	// Sliced sum with registered carries equals a flat add of the inputs
	a_sum: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> out == $past(a, ADD_STAGES) + $past(b, ADD_STAGES));

endmodule

/* hdl/x25519_streaming_squeeze.sv */
`timescale 1ns/1ns

module x25519_streaming_squeeze (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       clear,
	input  logic                       col_valid,
	input  x25519_field_pkg::column_t  col,
	output logic                       add_en,
	output x25519_field_pkg::wide_t    add_a,
	output x25519_field_pkg::wide_t    add_b
);
	import x25519_field_pkg::*;
	import x25519_seq_pkg::*;

	// Index of the incoming column and of the word being retired
	limb_idx_t  idx_q;
	limb_idx_t  idx_ff_q;
	logic       finishing_q;

	// Running word, column plus carry from the limb below
	column_t    word_q;

	////////////////////////////////////////////////////////////////////////////
	// Control

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			idx_q       <= '0;
			idx_ff_q    <= '0;
			finishing_q <= 1'b0;
			add_en      <= 1'b0;
		end else begin
			finishing_q <= 1'b0;
			add_en      <= finishing_q;

			// New operation
			if (clear) begin
				idx_q    <= '0;
				idx_ff_q <= '0;
			end

			if (col_valid) begin
				idx_ff_q <= idx_q;
				idx_q    <= idx_q + limb_idx_t'(1);
				// Last column in, retire the top word next cycle
				if (idx_q == limb_idx_t'(NUM_LIMBS - 1))
					finishing_q <= 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Ripple carry and overflow fold

	always_ff @(posedge clk) begin
		if (clear)
			word_q <= '0;

		if (col_valid) begin
			// Low byte of the previous word is final
			add_a[idx_ff_q*LIMB_W +: LIMB_W] <= word_q[LIMB_W-1:0];
			// Carry the rest into this column
			word_q <= (word_q >> LIMB_W) + col;
		end

		if (finishing_q) begin
			add_a[idx_ff_q*LIMB_W +: LIMB_W] <= word_q[LIMB_W-1:0];
			// Bits 255 and up leave the low operand...
			add_a[WIDE_W-1:FIELD_W-1] <= '0;
			// ...and come back times 19, top word bit 7 is bit 255 of t
			add_b <= wide_t'(word_q >> (FIELD_W - 1 - (NUM_LIMBS - 1) * LIMB_W))
				* wide_t'(FOLD_SQUEEZE);
		end
	end

	// One sum per operation
	a_add_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		add_en |=> !add_en);

endmodule

/* hdl/x25519_column_mult.sv */
`timescale 1ns/1ns

module x25519_column_mult (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       start,
	input  x25519_field_pkg::field_t   a,
	input  x25519_field_pkg::field_t   b,
	output logic                       busy,
	output logic                       clear,
	output logic                       col_valid,
	output x25519_field_pkg::column_t  col
);
	import x25519_field_pkg::*;
	import x25519_seq_pkg::*;

	mult_state_t                      state_q;
	limb_idx_t                        col_idx_q;
	logic                             cols_done_q;
	logic [$clog2(DRAIN_CYCLES)-1:0]  drain_q;

	// Captured operands, b held limb-rotated so limb j lines up with a_j
	field_t   a_q;
	field_t   b_rot_q;
	column_t  col_next;

	// Busy for the whole operation, including the squeeze and adder drain
	assign busy = (state_q == RUN);

	////////////////////////////////////////////////////////////////////////////
	// Column sum for the current index

	always_comb begin : p_col_sum
		limb_t    a_limb;
		limb_t    b_limb;
		column_t  prod;
		col_next = '0;
		for (int j = 0; j < NUM_LIMBS; j++) begin
			a_limb = a_q[j*LIMB_W +: LIMB_W];
			b_limb = b_rot_q[j*LIMB_W +: LIMB_W];
			prod   = column_t'(a_limb) * column_t'(b_limb);
			// Terms with j above the column index wrapped past 2^256
			if (limb_idx_t'(j) > col_idx_q)
				col_next = col_next + prod * column_t'(FOLD_MULT);
			else
				col_next = col_next + prod;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Control

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q     <= IDLE;
			col_idx_q   <= '0;
			cols_done_q <= 1'b0;
			drain_q     <= '0;
			clear       <= 1'b0;
			col_valid   <= 1'b0;
		end else begin
			clear     <= 1'b0;
			col_valid <= 1'b0;
			case (state_q)
				// start outside IDLE is simply not looked at
				IDLE: begin
					if (start) begin
						state_q     <= RUN;
						col_idx_q   <= '0;
						cols_done_q <= 1'b0;
						drain_q     <= '0;
						clear       <= 1'b1;
					end
				end
				RUN: begin
					if (!cols_done_q) begin
						// One column per clock, 0 to 31
						col_valid <= 1'b1;
						col_idx_q <= col_idx_q + limb_idx_t'(1);
						if (col_idx_q == limb_idx_t'(NUM_LIMBS - 1))
							cols_done_q <= 1'b1;
					end else if (drain_q == DRAIN_CYCLES - 1) begin
						// Drops on the same edge that raises done
						state_q <= IDLE;
					end else begin
						drain_q <= drain_q + 1'b1;
					end
				end
				default: state_q <= IDLE;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Operand and column registers

	always_ff @(posedge clk) begin
		if (state_q == IDLE && start) begin
			a_q <= a;
			// Limb j starts as b_(-j mod 32)
			for (int j = 0; j < NUM_LIMBS; j++)
				b_rot_q[j*LIMB_W +: LIMB_W] <= b[((NUM_LIMBS - j) % NUM_LIMBS)*LIMB_W +: LIMB_W];
		end else if (state_q == RUN && !cols_done_q) begin
			col     <= col_next;
			// Step to the next column, limb j gets b_(i+1-j)
			b_rot_q <= {b_rot_q[FIELD_W-LIMB_W-1:0], b_rot_q[FIELD_W-1 -: LIMB_W]};
		end
	end

	// A burst of columns never runs past one operand's worth
	a_col_burst: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(col_valid) |-> ##[1:NUM_LIMBS] !col_valid);

endmodule

/* hdl/x25519_seq_pkg.sv */
package x25519_seq_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Sequencing

	// Index of a limb or a column, 0 to 31
	typedef logic [4:0] limb_idx_t;

	// Multiplier control
	typedef enum logic {
		IDLE,
		RUN
	} mult_state_t;

	// Adder pipeline geometry, 4 x 66 = 264 bits
	localparam int unsigned ADD_STAGES  = 4;
	localparam int unsigned ADD_SLICE_W = 66;

	// Squeeze latency from the last column to the adder enable
	localparam int unsigned SQUEEZE_LAT = 2;

	// Cycles the multiplier stays busy after its last column
	localparam int unsigned DRAIN_CYCLES = SQUEEZE_LAT + ADD_STAGES;

endpackage

/* hdl/x25519_field_pkg.sv */
package x25519_field_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Number representation

	// One limb of an operand
	localparam int unsigned LIMB_W = 8;

	// Limbs per 256-bit operand
	localparam int unsigned NUM_LIMBS = 32;

	// Column sum straight out of the multiplier, worst case is about 8e7
	localparam int unsigned COL_W = 32;

	// Full operand width
	localparam int unsigned FIELD_W = 256;

	// Adder width, with headroom above the operand
	localparam int unsigned WIDE_W = 264;

	////////////////////////////////////////////////////////////////////////////
	// Folding constants for p = 2^255 - 19

	// 2^256 is congruent to 38, used on wrapped columns
	localparam int unsigned FOLD_MULT = 38;

	// 2^255 is congruent to 19, used on the carry out of the top limb
	localparam int unsigned FOLD_SQUEEZE = 19;

	typedef logic [LIMB_W-1:0]  limb_t;
	typedef logic [COL_W-1:0]   column_t;
	typedef logic [FIELD_W-1:0] field_t;
	typedef logic [WIDE_W-1:0]  wide_t;

endpackage
